//--- Bender.yml
package:
  name: cache_4way

sources:
  - src/cache_pkg.sv
  - src/sync_ram.sv
  - src/way_if.sv
  - src/cache_way.sv
  - src/lru_order.sv
  - src/cache_ctrl.sv
  - src/cache_top.sv
  - target: simulation
    files:
      - sim/cache_chk.sv
      - sim/cache_scoreboard.sv
      - sim/cache_tb.sv

//--- cache_4way.f
src/cache_pkg.sv
src/sync_ram.sv
src/way_if.sv
src/cache_way.sv
src/lru_order.sv
src/cache_ctrl.sv
src/cache_top.sv
sim/cache_chk.sv
sim/cache_scoreboard.sv
sim/cache_tb.sv

//--- sim/cache_chk.sv
`timescale 1ns/1ps

module cache_chk (
    input logic                 clk,
    input logic                 rst,
    input cache_pkg::way_mask_t i_way_hit,
    input logic                 i_m_read,
    input logic                 i_m_write,
    input logic                 i_p_readdata_valid,
    input logic                 i_p_waitrequest
);

    // a line is never held by two ways of the same set
    assert property (@(posedge clk) disable iff (rst) $onehot0(i_way_hit))
        else $error("more than one way hit in the same cycle");

    assert property (@(posedge clk) disable iff (rst) !(i_m_read && i_m_write))
        else $error("memory read and write strobes high together");

    assert property (@(posedge clk) disable iff (rst)
        i_p_readdata_valid |=> !i_p_readdata_valid)
        else $error("readdata_valid held for two cycles");

    // the processor is stalled for as long as memory is in use
    assert property (@(posedge clk) disable iff (rst)
        (i_m_read || i_m_write) |-> i_p_waitrequest)
        else $error("memory strobe high while processor waitrequest is low");

endmodule

bind cache_ctrl cache_chk u_chk (
    .clk                (clk),
    .rst                (rst),
    .i_way_hit          (way_hit),
    .i_m_read           (o_m_read),
    .i_m_write          (o_m_write),
    .i_p_readdata_valid (o_p_readdata_valid),
    .i_p_waitrequest    (o_p_waitrequest)
);

//--- sim/cache_scoreboard.sv
`timescale 1ns/1ps

module cache_scoreboard (
    input  logic                             clk,
    input  logic                             rst,
    input  cache_pkg::word_t                 i_p_readdata,
    input  logic                             i_p_readdata_valid,
    input  logic [cache_pkg::MEM_ADDR_W-1:0] i_m_addr,
    input  cache_pkg::line_t                 i_m_writedata,
    input  logic                             i_m_write,
    input  logic                             i_m_waitrequest,
    input  cache_pkg::word_t                 i_exp_word,
    input  cache_pkg::line_t                 i_exp_line,
    output int                               o_errors
);
    import cache_pkg::*;

    int reads_checked = 0;
    int lines_checked = 0;

    initial o_errors = 0;

    //////////////////////////////////////////////////
    // compare read beats and accepted writebacks

    always @(posedge clk) begin
        if (!rst && i_p_readdata_valid) begin
            reads_checked++;
            if (i_p_readdata !== i_exp_word) begin
                $display("FAIL at %0t: read data %h, expected %h",
                         $time, i_p_readdata, i_exp_word);
                o_errors++;
            end
        end
        if (!rst && i_m_write && !i_m_waitrequest) begin
            lines_checked++;
            if (i_m_writedata !== i_exp_line) begin
                $display("FAIL at %0t: writeback to %h carried %h, expected %h",
                         $time, i_m_addr, i_m_writedata, i_exp_line);
                o_errors++;
            end
        end
    end

    task automatic print_summary(input int seq_errors);
        $display("reads checked %0d, writebacks checked %0d, data errors %0d, sequence errors %0d",
                 reads_checked, lines_checked, o_errors, seq_errors);
    endtask

endmodule

//--- sim/cache_tb.sv
`timescale 1ns/1ps

module cache_tb;
    import cache_pkg::*;

    localparam int    INDEX_W  = 4;
    localparam int    N_RANDOM = 300;
    localparam int    NUM_OPS  = N_RANDOM + 40;
    localparam word_t PATTERN  = 32'h5a5a_0000;

    logic              clk;
    logic              rst;
    logic [ADDR_W-1:0] i_p_addr;
    logic [3:0]        i_p_byte_en;
    word_t             i_p_writedata;
    logic              i_p_read;
    logic              i_p_write;
    word_t             o_p_readdata;
    logic              o_p_readdata_valid;
    logic              o_p_waitrequest;
    logic [MEM_ADDR_W-1:0] o_m_addr;
    line_t             o_m_writedata;
    logic              o_m_read;
    logic              o_m_write;
    line_t             i_m_readdata;
    logic              i_m_readdata_valid;
    logic              i_m_waitrequest;

    int         seed      = 32'h4d2a_ceee;
    int         tb_errors = 0;
    int         sb_errors;
    word_t      shadow [int];
    word_t      mem_words [int];
    line_addr_t wb_log [$];
    word_t      exp_word;
    line_t      exp_line;

    cache_top #(.INDEX_W(INDEX_W)) u_dut (.*);

    cache_scoreboard u_sb (
        .clk (clk), .rst (rst),
        .i_p_readdata (o_p_readdata), .i_p_readdata_valid (o_p_readdata_valid),
        .i_m_addr (o_m_addr), .i_m_writedata (o_m_writedata),
        .i_m_write (o_m_write), .i_m_waitrequest (i_m_waitrequest),
        .i_exp_word (exp_word), .i_exp_line (exp_line), .o_errors (sb_errors)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(NUM_OPS * 40 * 20);
        $display("the run timed out after %0d operations worth of cycles", NUM_OPS);
        $display("FAIL: see errors above");
        $finish;
    end

    //////////////////////////////////////////////////
    // reference model

    // last byte-merged write, or the memory's initial pattern
    function automatic word_t ref_read(input logic [ADDR_W-1:0] addr);
        if (shadow.exists(addr)) return shadow[addr];
        return word_t'(addr) ^ PATTERN;
    endfunction

    function automatic line_t ref_line(input line_addr_t line);
        line_t l;
        for (int w = 0; w < WORDS_PER_LINE; w++) l[w] = ref_read({line, 2'(w)});
        return l;
    endfunction

    function automatic word_t mem_word(input logic [ADDR_W-1:0] addr);
        if (mem_words.exists(addr)) return mem_words[addr];
        return word_t'(addr) ^ PATTERN;
    endfunction

    function automatic line_addr_t make_line(input int tag, input int idx);
        return line_addr_t'((tag << INDEX_W) | idx);
    endfunction

    //////////////////////////////////////////////////
    // memory model with random stalls and read latency

    initial begin : memory_model
        line_addr_t line;
        line_t      wdata;
        logic       is_write;
        int         stall;
        i_m_waitrequest    = 1'b1;
        i_m_readdata_valid = 1'b0;
        i_m_readdata       = '0;
        forever begin
            @(posedge clk);
            #2;
            if (o_m_read || o_m_write) begin
                stall = $unsigned($random(seed)) % 4;
                repeat (stall) begin
                    @(posedge clk);
                    #2;
                end
                line     = o_m_addr[MEM_ADDR_W-1:3];
                is_write = o_m_write;
                wdata    = o_m_writedata;
                if (is_write) exp_line = ref_line(line);
                i_m_waitrequest = 1'b0;
                @(posedge clk);
                #2 i_m_waitrequest = 1'b1;
                if (is_write) begin
                    for (int w = 0; w < WORDS_PER_LINE; w++) mem_words[{line, 2'(w)}] = wdata[w];
                    wb_log.push_back(line);
                end else begin
                    repeat ($unsigned($random(seed)) % 4) @(posedge clk);
                    @(posedge clk);
                    #2;
                    for (int w = 0; w < WORDS_PER_LINE; w++)
                        i_m_readdata[w] = mem_word({line, 2'(w)});
                    i_m_readdata_valid = 1'b1;
                    @(posedge clk);
                    #2 i_m_readdata_valid = 1'b0;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // stimulus

    task automatic flag_error(input string msg);
        $display("FAIL at %0t: %s", $time, msg);
        tb_errors++;
    endtask

    // lat counts falling edges from acceptance to completion
    task automatic run_op(input logic wr, input logic [ADDR_W-1:0] addr, input logic [3:0] be,
                          input word_t data, output int lat);
        word_t merged;
        while (o_p_waitrequest) begin
            @(posedge clk);
            #2;
        end
        merged = ref_read(addr);
        if (wr) begin
            for (int b = 0; b < 4; b++) if (be[b]) merged[8*b +: 8] = data[8*b +: 8];
            shadow[addr] = merged;
        end else begin
            exp_word = merged;
        end
        i_p_addr      = addr;
        i_p_byte_en   = be;
        i_p_writedata = data;
        i_p_read      = !wr;
        i_p_write     = wr;
        @(posedge clk);
        #2;
        i_p_read  = 1'b0;
        i_p_write = 1'b0;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (wr ? o_p_waitrequest : !o_p_readdata_valid);
        @(posedge clk);
        #2;
    endtask

    initial begin
        int                lat;
        int                n_wb;
        logic [ADDR_W-1:0] a;
        rst = 1'b1;
        i_p_addr = '0;
        i_p_byte_en = '0;
        i_p_writedata = '0;
        i_p_read = 1'b0;
        i_p_write = 1'b0;
        repeat (5) @(posedge clk);
        #2 rst = 1'b0;

        // cold read, then a hit on the filled line
        a = {make_line(7, 2), 2'd1};
        run_op(1'b0, a, 4'h0, '0, lat);
        run_op(1'b0, a, 4'h0, '0, lat);
        if (lat != 2) flag_error($sformatf("read hit took %0d cycles, expected 2", lat));

        // write hit, then write-allocate on a miss
        run_op(1'b1, a, 4'b0101, 32'hdead_beef, lat);
        run_op(1'b0, a, 4'h0, '0, lat);
        a = {make_line(8, 3), 2'd2};
        run_op(1'b1, a, 4'b1100, 32'h1234_5678, lat);
        run_op(1'b0, a, 4'h0, '0, lat);

        // five dirty lines in one set evict the oldest
        n_wb = wb_log.size();
        for (int t = 1; t <= 5; t++)
            run_op(1'b1, {make_line(t, 5), 2'(t)}, 4'hf, 32'h0bad_0000 + t, lat);
        if (wb_log.size() == n_wb || wb_log[$] != make_line(1, 5))
            flag_error("five dirty lines in set 5 did not write back the oldest line");
        run_op(1'b0, {make_line(1, 5), 2'd1}, 4'h0, '0, lat);

        // A B C D written, A read, E must evict B
        for (int t = 0; t < 4; t++)
            run_op(1'b1, {make_line(17 + t, 9), 2'd0}, 4'hf, 32'hc0de_0000 + t, lat);
        run_op(1'b0, {make_line(17, 9), 2'd0}, 4'h0, '0, lat);
        n_wb = wb_log.size();
        run_op(1'b0, {make_line(21, 9), 2'd0}, 4'h0, '0, lat);
        if (wb_log.size() == n_wb || wb_log[$] != make_line(18, 9))
            flag_error("the fifth line in set 9 did not evict the least recently used line");

        repeat (N_RANDOM) begin
            a = {make_line(32 + $unsigned($random(seed)) % 3, $unsigned($random(seed)) % 16),
                 2'($unsigned($random(seed)) % 4)};
            run_op(1'($random(seed)), a, 4'(1 + $unsigned($random(seed)) % 15), $random(seed), lat);
        end

        repeat (4) @(posedge clk);
        u_sb.print_summary(tb_errors);
        if (tb_errors + sb_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- src/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl #(
    parameter int INDEX_W = 14
) (
    input  logic                             clk,
    input  logic                             rst,

    input  logic [cache_pkg::ADDR_W-1:0]     i_p_addr,
    input  logic [3:0]                       i_p_byte_en,
    input  cache_pkg::word_t                 i_p_writedata,
    input  logic                             i_p_read,
    input  logic                             i_p_write,
    output cache_pkg::word_t                 o_p_readdata,
    output logic                             o_p_readdata_valid,
    output logic                             o_p_waitrequest,

    output logic [cache_pkg::MEM_ADDR_W-1:0] o_m_addr,
    output cache_pkg::line_t                 o_m_writedata,
    output logic                             o_m_read,
    output logic                             o_m_write,
    input  cache_pkg::line_t                 i_m_readdata,
    input  logic                             i_m_readdata_valid,
    input  logic                             i_m_waitrequest,

    way_if.ctrl                              ways [cache_pkg::NUM_WAYS],

    output logic [INDEX_W-1:0]               o_lru_index,
    output logic                             o_lru_touch,
    output cache_pkg::way_id_t               o_lru_way,
    output logic                             o_lru_restart,
    input  cache_pkg::order_t                i_lru_order
);
    import cache_pkg::*;

    localparam int TAG_W = LINE_ADDR_W - INDEX_W;

    ctrl_state_e         state;
    logic [ADDR_W-1:0]   req_addr;
    word_t               req_wdata;
    logic [3:0]          req_be;
    logic                req_write;
    way_id_t             sel_way;

    logic [ADDR_W-1:0]   cur_addr;
    line_addr_t          cur_line;
    logic [TAG_W-1:0]    cur_tag;

    way_mask_t           way_hit;
    way_mask_t           way_valid;
    way_mask_t           way_dirty;
    way_mask_t           write_mask;
    line_t               way_rdata [NUM_WAYS];
    line_addr_t          way_victim [NUM_WAYS];

    logic                any_hit;
    way_id_t             hit_way;
    way_id_t             victim_way;
    logic                victim_dirty;
    logic                filling;
    logic                write_now;
    line_t               lane_wdata;
    logic [3:0]          lane_byte_en;
    logic [3:0]          lane_word_en;

    //////////////////////////////////////////////////
    // way requests and status

    // the incoming address is looked up while idle so status is ready in COMPARE
    assign cur_addr = (state == IDLE) ? i_p_addr : req_addr;
    assign cur_line = cur_addr[ADDR_W-1:2];
    assign cur_tag  = cur_line[LINE_ADDR_W-1:INDEX_W];

    assign filling   = (state == FETCH_WAIT);
    assign write_now = (state == WRITE_HIT) || (state == FILL_WRITE)
                       || (filling && i_m_readdata_valid);

    assign write_mask   = write_now ? (way_mask_t'(1) << sel_way) : '0;
    assign lane_wdata   = filling ? i_m_readdata : {WORDS_PER_LINE{req_wdata}};
    assign lane_byte_en = filling ? 4'hf : req_be;
    assign lane_word_en = filling ? 4'hf : (4'b0001 << req_addr[1:0]);

    for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way
        assign ways[g].index      = cur_line[INDEX_W-1:0];
        assign ways[g].tag        = cur_tag;
        assign ways[g].wdata      = lane_wdata;
        assign ways[g].byte_en    = lane_byte_en;
        assign ways[g].word_en    = lane_word_en;
        assign ways[g].write      = write_mask[g];
        assign ways[g].mark_dirty = !filling;

        assign way_hit[g]    = ways[g].hit;
        assign way_valid[g]  = ways[g].valid;
        assign way_dirty[g]  = ways[g].dirty;
        assign way_rdata[g]  = ways[g].rdata;
        assign way_victim[g] = ways[g].victim_addr;
    end

    assign any_hit = |way_hit;

    // lowest hitting way, and the lowest invalid way before falling back to LRU slot 0
    always_comb begin
        hit_way    = '0;
        victim_way = i_lru_order[0];
        for (int k = NUM_WAYS - 1; k >= 0; k--) begin
            if (way_hit[k]) begin
                hit_way = way_id_t'(k);
            end
            if (!way_valid[k]) begin
                victim_way = way_id_t'(k);
            end
        end
    end

    assign victim_dirty = way_valid[victim_way] && way_dirty[victim_way];

    //////////////////////////////////////////////////
    // replacement order update

    assign o_lru_index   = cur_line[INDEX_W-1:0];
    assign o_lru_touch   = (state == COMPARE);
    assign o_lru_way     = any_hit ? hit_way : victim_way;
    assign o_lru_restart = (state == COMPARE) && !any_hit && !way_valid[0];

    assign o_p_waitrequest = (state != IDLE);

    //////////////////////////////////////////////////
    // request FSM

    always_ff @(posedge clk) begin
        if (rst) begin
            state              <= IDLE;
            req_write          <= 1'b0;
            sel_way            <= '0;
            o_p_readdata_valid <= 1'b0;
            o_m_read           <= 1'b0;
            o_m_write          <= 1'b0;
        end else begin
            o_p_readdata_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (i_p_read || i_p_write) begin
                        req_write <= i_p_write;
                        state     <= COMPARE;
                    end
                end
                COMPARE: begin
                    if (any_hit) begin
                        sel_way <= hit_way;
                        if (req_write) begin
                            state <= WRITE_HIT;
                        end else begin
                            o_p_readdata_valid <= 1'b1;
                            state              <= IDLE;
                        end
                    end else begin
                        sel_way <= victim_way;
                        if (victim_dirty) begin
                            state <= WB_LOAD;
                        end else begin
                            o_m_read <= 1'b1;
                            state    <= FETCH_REQ;
                        end
                    end
                end
                FETCH_REQ: begin
                    if (!i_m_waitrequest) begin
                        o_m_read <= 1'b0;
                        state    <= FETCH_WAIT;
                    end
                end
                FETCH_WAIT: begin
                    if (i_m_readdata_valid) begin
                        if (req_write) begin
                            state <= FILL_WRITE;
                        end else begin
                            o_p_readdata_valid <= 1'b1;
                            state              <= IDLE;
                        end
                    end
                end
                WB_LOAD: begin
                    o_m_write <= 1'b1;
                    state     <= WB_REQ;
                end
                WB_REQ: begin
                    // the refill is requested as soon as the victim line is taken
                    if (!i_m_waitrequest) begin
                        o_m_write <= 1'b0;
                        o_m_read  <= 1'b1;
                        state     <= FETCH_REQ;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            req_addr  <= i_p_addr;
            req_wdata <= i_p_writedata;
            req_be    <= i_p_byte_en;
        end
        if (state == COMPARE) begin
            o_p_readdata <= way_rdata[hit_way][req_addr[1:0]];
            o_m_addr     <= {req_addr[ADDR_W-1:2], 3'b000};
        end
        if (filling && i_m_readdata_valid) begin
            o_p_readdata <= i_m_readdata[req_addr[1:0]];
        end
        if (state == WB_LOAD) begin
            o_m_addr      <= {way_victim[sel_way], 3'b000};
            o_m_writedata <= way_rdata[sel_way];
        end
        if (state == WB_REQ && !i_m_waitrequest) begin
            o_m_addr <= {req_addr[ADDR_W-1:2], 3'b000};
        end
    end

endmodule

//--- src/cache_pkg.sv
package cache_pkg;

    //////////////////////////////////////////////////
    // address and data widths

    localparam int ADDR_W         = 25;
    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_W         = WORDS_PER_LINE * WORD_W;
    localparam int NUM_WAYS       = 4;

    // a word address is the line address with the word lane below it
    localparam int LINE_ADDR_W    = ADDR_W - 2;
    localparam int MEM_ADDR_W     = LINE_ADDR_W + 3;

    //////////////////////////////////////////////////
    // data types

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [WORDS_PER_LINE-1:0][WORD_W-1:0] line_t;
    typedef logic [LINE_ADDR_W-1:0] line_addr_t;
    typedef logic [NUM_WAYS-1:0] way_mask_t;
    typedef logic [$clog2(NUM_WAYS)-1:0] way_id_t;

    // slot 0 is the least recently used way, slot 3 the most recent one
    typedef way_id_t [NUM_WAYS-1:0] order_t;

    typedef enum logic [2:0] {
        IDLE,
        COMPARE,
        WRITE_HIT,
        FETCH_REQ,
        FETCH_WAIT,
        FILL_WRITE,
        WB_LOAD,
        WB_REQ
    } ctrl_state_e;

endpackage

//--- src/cache_top.sv
`timescale 1ns/1ps

module cache_top #(
    parameter int INDEX_W = 14
) (
    input  logic                             clk,
    input  logic                             rst,

    input  logic [cache_pkg::ADDR_W-1:0]     i_p_addr,
    input  logic [3:0]                       i_p_byte_en,
    input  cache_pkg::word_t                 i_p_writedata,
    input  logic                             i_p_read,
    input  logic                             i_p_write,
    output cache_pkg::word_t                 o_p_readdata,
    output logic                             o_p_readdata_valid,
    output logic                             o_p_waitrequest,

    output logic [cache_pkg::MEM_ADDR_W-1:0] o_m_addr,
    output cache_pkg::line_t                 o_m_writedata,
    output logic                             o_m_read,
    output logic                             o_m_write,
    input  cache_pkg::line_t                 i_m_readdata,
    input  logic                             i_m_readdata_valid,
    input  logic                             i_m_waitrequest
);
    import cache_pkg::*;

    logic [INDEX_W-1:0] lru_index;
    logic               lru_touch;
    way_id_t            lru_way;
    logic               lru_restart;
    order_t             lru_word;

    way_if #(.INDEX_W(INDEX_W)) way_bus [NUM_WAYS] ();

    cache_ctrl #(
        .INDEX_W (INDEX_W)
    ) u_ctrl (
        .clk                (clk),
        .rst                (rst),
        .i_p_addr           (i_p_addr),
        .i_p_byte_en        (i_p_byte_en),
        .i_p_writedata      (i_p_writedata),
        .i_p_read           (i_p_read),
        .i_p_write          (i_p_write),
        .o_p_readdata       (o_p_readdata),
        .o_p_readdata_valid (o_p_readdata_valid),
        .o_p_waitrequest    (o_p_waitrequest),
        .o_m_addr           (o_m_addr),
        .o_m_writedata      (o_m_writedata),
        .o_m_read           (o_m_read),
        .o_m_write          (o_m_write),
        .i_m_readdata       (i_m_readdata),
        .i_m_readdata_valid (i_m_readdata_valid),
        .i_m_waitrequest    (i_m_waitrequest),
        .ways               (way_bus),
        .o_lru_index        (lru_index),
        .o_lru_touch        (lru_touch),
        .o_lru_way          (lru_way),
        .o_lru_restart      (lru_restart),
        .i_lru_order        (lru_word)
    );

    for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way
        cache_way #(
            .INDEX_W (INDEX_W)
        ) u_way (
            .clk (clk),
            .bus (way_bus[g])
        );
    end

    lru_order #(
        .INDEX_W (INDEX_W)
    ) u_lru (
        .clk       (clk),
        .i_index   (lru_index),
        .i_touch   (lru_touch),
        .i_way     (lru_way),
        .i_restart (lru_restart),
        .o_order   (lru_word)
    );

endmodule

//--- src/cache_way.sv
`timescale 1ns/1ps

module cache_way #(
    parameter int INDEX_W = 14
) (
    input logic clk,
    way_if.way  bus
);
    import cache_pkg::*;

    localparam int TAG_W          = LINE_ADDR_W - INDEX_W;
    localparam int LANES          = LINE_W / 8;
    localparam int LANES_PER_WORD = WORD_W / 8;

    logic [7:0]       lane_rdata [LANES];
    logic [TAG_W+1:0] tag_word;
    logic [TAG_W-1:0] stored_tag;
    logic             stored_valid;
    logic             stored_dirty;

    //////////////////////////////////////////////////
    // data storage, one RAM per byte of the line

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        logic lane_we;

        assign lane_we = bus.write
                         && bus.word_en[l / LANES_PER_WORD]
                         && bus.byte_en[l % LANES_PER_WORD];

        sync_ram #(
            .DATA_W  (8),
            .DEPTH_W (INDEX_W)
        ) u_lane (
            .clk     (clk),
            .i_we    (lane_we),
            .i_addr  (bus.index),
            .i_wdata (bus.wdata[l / LANES_PER_WORD][(l % LANES_PER_WORD)*8 +: 8]),
            .o_rdata (lane_rdata[l])
        );
    end

    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            bus.rdata[l / LANES_PER_WORD][(l % LANES_PER_WORD)*8 +: 8] = lane_rdata[l];
        end
    end

    //////////////////////////////////////////////////
    // tag storage

    // every write, fill or store, leaves the line valid under the request tag
    sync_ram #(
        .DATA_W  (TAG_W + 2),
        .DEPTH_W (INDEX_W)
    ) u_tag (
        .clk     (clk),
        .i_we    (bus.write),
        .i_addr  (bus.index),
        .i_wdata ({bus.mark_dirty, 1'b1, bus.tag}),
        .o_rdata (tag_word)
    );

    assign stored_dirty = tag_word[TAG_W+1];
    assign stored_valid = tag_word[TAG_W];
    assign stored_tag   = tag_word[TAG_W-1:0];

    assign bus.hit   = stored_valid && (stored_tag == bus.tag);
    assign bus.valid = stored_valid;
    assign bus.dirty = stored_dirty;

    // the index is held by the controller while the status is in use
    assign bus.victim_addr = {stored_tag, bus.index};

endmodule

//--- src/lru_order.sv
`timescale 1ns/1ps

module lru_order #(
    parameter int INDEX_W = 14
) (
    input  logic               clk,
    input  logic [INDEX_W-1:0] i_index,
    input  logic               i_touch,
    input  cache_pkg::way_id_t i_way,
    input  logic               i_restart,
    output cache_pkg::order_t  o_order
);
    import cache_pkg::*;

    // slot k holds way k
    localparam order_t IDENTITY = {2'd3, 2'd2, 2'd1, 2'd0};

    order_t base_order;
    order_t next_order;
    logic   found;

    //////////////////////////////////////////////////
    // promotion of the touched way to slot 3

    always_comb begin
        base_order = i_restart ? IDENTITY : o_order;
        found      = 1'b0;
        for (int k = 0; k < NUM_WAYS - 1; k++) begin
            if (base_order[k] == i_way) begin
                found = 1'b1;
            end
            // slots from the touched way upward move down by one
            next_order[k] = found ? base_order[k + 1] : base_order[k];
        end
        next_order[NUM_WAYS - 1] = i_way;
    end

    sync_ram #(
        .DATA_W  ($bits(order_t)),
        .DEPTH_W (INDEX_W)
    ) u_order (
        .clk     (clk),
        .i_we    (i_touch),
        .i_addr  (i_index),
        .i_wdata (next_order),
        .o_rdata (o_order)
    );

endmodule

//--- src/sync_ram.sv
`timescale 1ns/1ps

module sync_ram #(
    parameter int DATA_W  = 8,
    parameter int DEPTH_W = 14
) (
    input  logic               clk,
    input  logic               i_we,
    input  logic [DEPTH_W-1:0] i_addr,
    input  logic [DATA_W-1:0]  i_wdata,
    output logic [DATA_W-1:0]  o_rdata
);

    logic [DATA_W-1:0] mem [2**DEPTH_W];

    initial begin
        for (int i = 0; i < 2**DEPTH_W; i++) begin
            mem[i] = '0;
        end
    end

    // read returns the old contents when the same address is written
    always @(posedge clk) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata;
        end
        o_rdata <= mem[i_addr];
    end

endmodule

//--- src/way_if.sv
`timescale 1ns/1ps

interface way_if #(
    parameter int INDEX_W = 14
);
    import cache_pkg::*;

    localparam int TAG_W = LINE_ADDR_W - INDEX_W;

    // request side, driven by the controller
    logic [INDEX_W-1:0]        index;
    logic [TAG_W-1:0]          tag;
    line_t                     wdata;
    logic [WORD_W/8-1:0]       byte_en;
    logic [WORDS_PER_LINE-1:0] word_en;
    logic                      write;
    logic                      mark_dirty;

    // status side, one cycle behind index
    line_t                     rdata;
    line_addr_t                victim_addr;
    logic                      hit;
    logic                      valid;
    logic                      dirty;

    modport ctrl (
        output index, tag, wdata, byte_en, word_en, write, mark_dirty,
        input  rdata, victim_addr, hit, valid, dirty
    );

    modport way (
        input  index, tag, wdata, byte_en, word_en, write, mark_dirty,
        output rdata, victim_addr, hit, valid, dirty
    );

endinterface
